// File: design/convDataPkg.sv
`default_nettype none

package convDataPkg;

	// --------------------
	// widths
	localparam int PROD_WIDTH = 16;                                 // one unsigned product
	localparam int MAX_TERMS = 32;                                  // longest row the widths allow
	localparam int ROW_SUM_WIDTH = PROD_WIDTH + $clog2(MAX_TERMS);  // 21 bits
	localparam int LANE_WIDTH = ROW_SUM_WIDTH + 2;                  // room for three row sums
	localparam int NUM_ROWS = 3;                                    // rows in a 3x3 window

	// --------------------
	// payload types
	typedef logic [PROD_WIDTH-1:0] product_t;
	typedef logic [ROW_SUM_WIDTH-1:0] rowSum_t;

	typedef struct packed {
		logic [LANE_WIDTH-1:0] front;  // upper lane, separated row
		logic [LANE_WIDTH-1:0] back;   // lower lane, remaining rows
	} psum_t;

	// one stage for the groups of three, then one per halving
	function automatic int treeLatency(input int terms);
		int nodes;
		int depth;
		nodes = (terms + 2) / 3;  // groups of three, last one padded
		depth = 1;
		while (nodes > 1) begin
			nodes = (nodes + 1) / 2;  // odd node passes through
			depth++;
		end
		return depth;
	endfunction

endpackage

`default_nettype wire

// File: design/convCtrlPkg.sv
`default_nettype none

package convCtrlPkg;

	// --------------------
	// lane split of the partial sum
	// code 2'd3 is unused and combines like SPLIT_NONE
	typedef enum logic [1:0] {
		SPLIT_NONE = 2'd0,  // back = row1 + row2 + row3
		SPLIT_ROW3 = 2'd1,  // front = row3, back = row1 + row2
		SPLIT_ROW1 = 2'd2   // front = row1, back = row2 + row3
	} splitMode_t;

	// --------------------
	// control that rides beside the data
	typedef struct packed {
		logic valid;        // window present this cycle
		splitMode_t split;  // how the rows go into the lanes
	} convCtrl_t;

	localparam convCtrl_t CTRL_IDLE = '{
		valid: 1'b0,
		split: SPLIT_NONE
	};  // empty pipeline slot

endpackage

`default_nettype wire

// File: design/rowAdderTree.sv
`timescale 1ns/1ns
`default_nettype none

module rowAdderTree
	import convDataPkg::*;
#(
	parameter int TERMS_PER_ROW = 24,  // 3 up to MAX_TERMS
	parameter int TREE_LATENCY = 4     // adder levels, from treeLatency()
) (
	input  logic     clk,
	input  logic     rst_n,
	input  product_t terms [TERMS_PER_ROW],
	output rowSum_t  rowSum  // changes TREE_LATENCY edges after terms are sampled
);

	// node count of a level, level 0 being the groups of three
	function automatic int nodesAt(input int lvl);
		int n;
		int i;
		n = (TERMS_PER_ROW + 2) / 3;
		for (i = 0; i < lvl; i++) begin
			n = (n + 1) / 2;  // pairs plus odd leftover
		end
		return n;
	endfunction

	// level l covers at most 3*2^l products, capped at the row sum width
	function automatic int widthAt(input int lvl);
		int w;
		w = PROD_WIDTH + 2 + lvl;
		if (w > ROW_SUM_WIDTH) begin
			w = ROW_SUM_WIDTH;  // a whole row never needs more
		end
		return w;
	endfunction

	localparam int GROUPS = nodesAt(0);  // 8 for 24 terms

	product_t termsQ [TERMS_PER_ROW];  // input stage
	product_t padded [3*GROUPS];       // zero fill of the short last group

	// --------------------
	// input register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			termsQ <= '{default: '0};
		end else begin
			termsQ <= terms;  // free running, no valid
		end
	end

	for (genvar i = 0; i < 3*GROUPS; i++) begin : padTerm
		if (i < TERMS_PER_ROW) begin : inRange
			assign padded[i] = termsQ[i];
		end else begin : zero
			assign padded[i] = '0;  // missing slot in last group
		end
	end

	// --------------------
	// adder levels
	for (genvar l = 0; l < TREE_LATENCY; l++) begin : level
		localparam int N = nodesAt(l);  // nodes on this level
		localparam int W = widthAt(l);  // bits per node

		logic [W-1:0] nxt [N];   // adder outputs
		logic [W-1:0] node [N];  // level register

		if (l == 0) begin : groupSum
			for (genvar g = 0; g < N; g++) begin : grp
				assign nxt[g] = W'(padded[3*g]) + W'(padded[3*g+1])
					+ W'(padded[3*g+2]);  // three products
			end
		end else begin : pairSum
			localparam int NP = nodesAt(l - 1);  // nodes below

			for (genvar n = 0; n < N; n++) begin : pair
				if (2*n + 1 < NP) begin : add
					assign nxt[n] = W'(level[l-1].node[2*n])
						+ W'(level[l-1].node[2*n+1]);
				end else begin : pass
					assign nxt[n] = W'(level[l-1].node[2*n]);  // odd one out
				end
			end
		end

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				node <= '{default: '0};
			end else begin
				node <= nxt;
			end
		end
	end

	// single node left on the top level
	assign rowSum = rowSum_t'(level[TREE_LATENCY-1].node[0]);

endmodule

`default_nettype wire

// File: design/rowCombiner.sv
`timescale 1ns/1ns
`default_nettype none

module rowCombiner
	import convDataPkg::*, convCtrlPkg::*;
#(
	parameter int TREE_LATENCY = 4  // adder levels in each row tree
) (
	input  logic      clk,
	input  logic      rst_n,
	input  rowSum_t   row1,
	input  rowSum_t   row2,
	input  rowSum_t   row3,
	input  convCtrl_t ctrlIn,     // same edge as the products
	output logic      psumValid,  // one pulse per window
	output psum_t     psum        // holds between windows
);

	// entry 0 matches the tree input register, the rest its levels
	localparam int DEPTH = TREE_LATENCY + 1;

	convCtrl_t ctrlPipe [DEPTH];  // control delay line
	convCtrl_t ctrlAligned;       // same window as row1..row3
	psum_t     psumNext;

	// --------------------
	// control delay line
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrlPipe <= '{default: CTRL_IDLE};  // no window in flight
		end else begin
			ctrlPipe[0] <= ctrlIn;
			for (int i = 1; i < DEPTH; i++) begin
				ctrlPipe[i] <= ctrlPipe[i-1];
			end
		end
	end

	assign ctrlAligned = ctrlPipe[DEPTH-1];  // meets the row sums

	// --------------------
	// lane split
	always_comb begin
		case (ctrlAligned.split)
			SPLIT_ROW3: begin
				psumNext.front = LANE_WIDTH'(row3);  // bottom row kept apart
				psumNext.back = LANE_WIDTH'(row1) + LANE_WIDTH'(row2);
			end
			SPLIT_ROW1: begin
				psumNext.front = LANE_WIDTH'(row1);  // top row kept apart
				psumNext.back = LANE_WIDTH'(row2) + LANE_WIDTH'(row3);
			end
			default: begin
				psumNext.front = '0;  // also the unused code
				psumNext.back = LANE_WIDTH'(row1) + LANE_WIDTH'(row2)
					+ LANE_WIDTH'(row3);  // whole window
			end
		endcase
	end

	// --------------------
	// output register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			psumValid <= 1'b0;
			psum <= '0;
		end else begin
			psumValid <= ctrlAligned.valid;
			if (ctrlAligned.valid) begin
				psum <= psumNext;  // else hold last window
			end
		end
	end

endmodule

`default_nettype wire

// File: design/convAdderSlice.sv
`timescale 1ns/1ns
`default_nettype none

module convAdderSlice
	import convDataPkg::*, convCtrlPkg::*;
#(
	parameter int TERMS_PER_ROW = 24  // products per window row
) (
	input  logic      clk,
	input  logic      rst_n,
	input  product_t  products [NUM_ROWS][TERMS_PER_ROW],  // row-major window products
	input  convCtrl_t ctrlIn,                               // valid and split for this window
	output logic      psumValid,
	output psum_t     psum
);

	// depth of every row tree, same for all rows
	localparam int TREE_LATENCY = treeLatency(TERMS_PER_ROW);

	rowSum_t row1;  // top window row
	rowSum_t row2;
	rowSum_t row3;  // bottom window row

	// --------------------
	// one reduction tree per row
	rowAdderTree #(
		.TERMS_PER_ROW(TERMS_PER_ROW),
		.TREE_LATENCY (TREE_LATENCY)
	) u_row1 (
		.clk   (clk),
		.rst_n (rst_n),
		.terms (products[0]),
		.rowSum(row1)
	);

	rowAdderTree #(
		.TERMS_PER_ROW(TERMS_PER_ROW),
		.TREE_LATENCY (TREE_LATENCY)
	) u_row2 (
		.clk   (clk),
		.rst_n (rst_n),
		.terms (products[1]),
		.rowSum(row2)
	);

	rowAdderTree #(
		.TERMS_PER_ROW(TERMS_PER_ROW),
		.TREE_LATENCY (TREE_LATENCY)
	) u_row3 (
		.clk   (clk),
		.rst_n (rst_n),
		.terms (products[2]),
		.rowSum(row3)
	);

	// --------------------
	// control delay and lane split
	rowCombiner #(
		.TREE_LATENCY(TREE_LATENCY)
	) u_combiner (
		.clk      (clk),
		.rst_n    (rst_n),
		.row1     (row1),
		.row2     (row2),
		.row3     (row3),
		.ctrlIn   (ctrlIn),     // raw, aligned inside
		.psumValid(psumValid),
		.psum     (psum)
	);

endmodule

`default_nettype wire

// File: testbench/tbClock.sv
`timescale 1ns/1ns
`default_nettype none

module tbClock #(
	parameter int PERIOD = 20,      // ns
	parameter int RESET_CYCLES = 5  // rising edges held in reset
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;  // falling edge at time zero starts the async reset
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;  // released just after an edge
	end

	always #(PERIOD/2) clk = ~clk;

endmodule

`default_nettype wire

// File: testbench/convAdder_assert.sv
`timescale 1ns/1ns
`default_nettype none

module convAdderAssert
	import convDataPkg::*, convCtrlPkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input convCtrl_t lastCtrl,   // last entry of the delay line
	input logic      psumValid,
	input psum_t     psum
);

	int failCount = 0;  // failed assertions so far

	validKnown: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(psumValid))
		else begin
			failCount++;
			$error("psumValid is unknown after reset");
		end

	validFollows: assert property (@(posedge clk) disable iff (!rst_n)
		lastCtrl.valid |=> psumValid)
		else begin
			failCount++;
			$error("psumValid missing one cycle after a valid aligned entry");
		end

	frontZero: assert property (@(posedge clk) disable iff (!rst_n)
		(lastCtrl.valid && lastCtrl.split == SPLIT_NONE) |=> (psum.front == '0))
		else begin
			failCount++;
			$error("front lane not zero for an unsplit window");
		end

	// psum only moves with a valid window
	psumHold: assert property (@(posedge clk) disable iff (!rst_n)
		!psumValid |-> $stable(psum))
		else begin
			failCount++;
			$error("psum changed while psumValid was low");
		end

endmodule

bind rowCombiner convAdderAssert u_assert (
	.clk      (clk),
	.rst_n    (rst_n),
	.lastCtrl (ctrlAligned),
	.psumValid(psumValid),
	.psum     (psum)
);

`default_nettype wire

// File: testbench/convAdderTb.sv
`timescale 1ns/1ns
`default_nettype none

module convAdderTb
	import convDataPkg::*, convCtrlPkg::*;
();

	localparam int TERMS = 24;         // default row length of the DUT
	localparam int PIPE_LATENCY = 5;   // sample edge to psum edge
	localparam int MAX_CYCLES = 2000;  // about 330 windows plus drain, with margin

	typedef product_t window_t [NUM_ROWS][TERMS];

	typedef struct packed {
		psum_t       expPsum;   // reference result
		logic [31:0] dueCycle;  // edge the result has to come on
	} pending_t;

	logic      clk;
	logic      rst_n;
	window_t   products;
	convCtrl_t ctrlIn;
	logic      psumValid;
	psum_t     psum;

	pending_t    expectQ [$];          // windows in flight
	psum_t       lastPsum = '0;        // last psum seen with psumValid
	logic [31:0] cycleCount = '0;      // rising edges so far

	tbClock u_clock (
		.clk  (clk),
		.rst_n(rst_n)
	);

	convAdderSlice u_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.products (products),
		.ctrlIn   (ctrlIn),
		.psumValid(psumValid),
		.psum     (psum)
	);

	// --------------------
	// checks and reference
	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s expected %0d, got %0d", $time, name,
				expected, actual);
			$display("Errors found");
			$fatal(1, "stopped at first failing check");
		end
	endtask

	// row totals, then the lane split
	function automatic psum_t expectPsum(input window_t win, input splitMode_t mode);
		logic [63:0] rowTot [NUM_ROWS];
		psum_t result;
		for (int r = 0; r < NUM_ROWS; r++) begin
			rowTot[r] = '0;
			for (int t = 0; t < TERMS; t++) begin
				rowTot[r] += win[r][t];
			end
		end
		case (mode)
			SPLIT_ROW3: begin
				result.front = LANE_WIDTH'(rowTot[2]);  // bottom row apart
				result.back = LANE_WIDTH'(rowTot[0] + rowTot[1]);
			end
			SPLIT_ROW1: begin
				result.front = LANE_WIDTH'(rowTot[0]);  // top row apart
				result.back = LANE_WIDTH'(rowTot[1] + rowTot[2]);
			end
			default: begin
				result.front = '0;
				result.back = LANE_WIDTH'(rowTot[0] + rowTot[1] + rowTot[2]);
			end
		endcase
		return result;
	endfunction

	// --------------------
	// stimulus helpers
	task automatic randomWindow(output window_t win);
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int t = 0; t < TERMS; t++) begin
				win[r][t] = product_t'($urandom);
			end
		end
	endtask

	task automatic fillWindow(output window_t win, input product_t value);
		win = '{default: value};
	endtask

	task automatic driveWindow(input window_t win, input splitMode_t mode);
		pending_t entry;
		@(posedge clk);
		#2;
		products = win;
		ctrlIn.valid = 1'b1;
		ctrlIn.split = mode;
		entry.expPsum = expectPsum(win, mode);
		entry.dueCycle = cycleCount + 1 + PIPE_LATENCY;  // sampled on the coming edge
		expectQ.push_back(entry);
	endtask

	task automatic driveIdle();
		window_t noise;
		randomWindow(noise);
		@(posedge clk);
		#2;
		products = noise;  // must be ignored
		ctrlIn.valid = 1'b0;
		ctrlIn.split = splitMode_t'($urandom_range(0, 2));
	endtask

	// --------------------
	// main sequence
	initial begin
		window_t win;
		splitMode_t mode;
		void'($urandom(32'h145f7f1c));
		products = '{default: '0};
		ctrlIn = CTRL_IDLE;
		#1;  // clock and reset have started

		// reset and the quiet cycles after it
		do begin
			@(negedge clk);
			checkValue("psumValid", 1'b0, psumValid);
			checkValue("psum", '0, psum);
		end while (rst_n !== 1'b1);
		repeat (5) begin
			@(negedge clk);
			checkValue("psumValid", 1'b0, psumValid);
			checkValue("psum", '0, psum);
		end

		// one mode at a time, none then row3 then row1
		for (int m = 0; m < 3; m++) begin
			repeat (40) begin
				randomWindow(win);
				driveWindow(win, splitMode_t'(m));
				if ($urandom_range(0, 4) == 0) begin
					driveIdle();
				end
			end
		end

		// mode changes on every window
		mode = SPLIT_NONE;
		repeat (150) begin
			mode = splitMode_t'((int'(mode) + 1 + $urandom_range(0, 1)) % 3);
			randomWindow(win);
			driveWindow(win, mode);
			if ($urandom_range(0, 3) == 0) begin
				driveIdle();  // random gap
			end
		end

		// full scale products, rows of 1572840
		fillWindow(win, 16'hFFFF);
		for (int m = 0; m < 3; m++) begin
			driveWindow(win, splitMode_t'(m));
		end

		repeat (20) driveIdle();  // noise only, psum holds
		repeat (PIPE_LATENCY + 3) @(posedge clk);

		if (expectQ.size() == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("%0d windows never came out of the DUT", expectQ.size());
			$display("Errors found");
			$fatal(1, "missing outputs");
		end
	end

	// --------------------
	// compare, on the falling edge
	always @(negedge clk) begin : compare
		pending_t entry;
		if (u_dut.u_combiner.u_assert.failCount != 0) begin
			$display("a concurrent assertion on rowCombiner failed");
			$display("Errors found");
			$fatal(1, "assertion failure");
		end else if (rst_n !== 1'b1) begin
			lastPsum = '0;  // reset clears psum
		end else if (psumValid === 1'b1) begin
			if (expectQ.size() == 0) begin
				$display("psumValid pulsed at %0t ns with no window pending", $time);
				$display("Errors found");
				$fatal(1, "unexpected output");
			end else begin
				entry = expectQ.pop_front();
				checkValue("output cycle", entry.dueCycle, cycleCount);
				checkValue("psum.front", entry.expPsum.front, psum.front);
				checkValue("psum.back", entry.expPsum.back, psum.back);
				lastPsum = psum;
			end
		end else begin
			checkValue("psumValid", 1'b0, psumValid);  // catches X
			checkValue("psum", lastPsum, psum);        // held between windows
		end
	end

	// cycle count and run limit
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= MAX_CYCLES) begin
			$display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors found");
			$fatal(1, "timeout");
		end
	end

endmodule

`default_nettype wire

// File: sim.f
design/convDataPkg.sv
design/convCtrlPkg.sv
design/rowAdderTree.sv
design/rowCombiner.sv
design/convAdderSlice.sv
testbench/tbClock.sv
testbench/convAdder_assert.sv
testbench/convAdderTb.sv
